// ==== build.f ====
rtl/fpTypesPkg.sv
rtl/fpuOpsPkg.sv
rtl/fpuAddSubAligner.sv
rtl/fpuFracAdder.sv
rtl/fpuNormalizer16.sv
rtl/fpuAddSub.sv
tb/fpuAddSub_asserts.sv
tb/fpuAddSubTb.sv

// ==== tb/fpuAddSub_tests.txt ====
# Columns: opcode (0 add, 1 subtract), operand A, operand B, expected result, all hex FP16.
# Expected values use truncation and the raw exponent field (bias 15) as the scale.
0 3C00 3C00 4000
0 3E00 3D00 4180
0 4000 3C00 4200
0 3C01 3801 3E01
0 3FFF 3C01 4200
0 3C01 3C00 4000
0 BC00 C000 C200
1 4200 3C00 4000
1 3C00 4200 C000
1 3C00 3B80 2C00
0 4500 C400 3C00
0 3C00 BD00 B400
1 4A40 48E0 4180
1 4A40 4A40 0000
0 C155 4155 0000
1 0A00 0900 0000
1 0E00 0D00 0400
0 8A00 0900 0000
0 0200 0100 0000
0 3C00 03FF 3C00
1 5000 1400 5000
0 0400 0200 0500
0 0800 03FF 08FF
0 3C00 1400 3C01
0 4000 1400 4000

// ==== tb/fpuAddSubTb.sv ====
`timescale 1ns/10ps

module fpuAddSubTb;
  import fpTypesPkg::*;
  import fpuOpsPkg::*;

  localparam int unsigned resetCycles = 3;   // Edges with rstN held low.
  localparam int unsigned groupSize   = 10;  // Operations sent back to back before a gap.
  localparam int unsigned gapCycles   = 4;   // Idle cycles after each group.
  localparam int unsigned replayCount = 3;   // Operations in flight when the second reset hits.

  logic   clk;
  logic   rstN;
  logic   inValid;
  fpuOp_e op;
  fp16_t  opA;
  fp16_t  opB;
  logic   outValid;
  fp16_t  result;

  fpuOp_e testOp[$];   // Opcode column of the data file.
  fp16_t  testA[$];    // Operand A column.
  fp16_t  testB[$];    // Operand B column.
  fp16_t  testExp[$];  // Expected result column, computed with truncation.

  fp16_t  expQ[$];     // Expected results of operations still in the pipeline.
  int     issueQ[$];   // Cycle in which each of those operations sat on the inputs.
  fp16_t  lastResult;  // Value the result port has to hold between strobes.
  int     cycleCount = 0;
  int     cycleLimit;

  fpuAddSub DUT (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .op       (op),
    .opA      (opA),
    .opB      (opB),
    .outValid (outValid),
    .result   (result)
  );

  bind fpuAddSub fpuAddSubAsserts uAsserts (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .outValid (outValid),
    .result   (result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                           // 10 ns period.
  end

  task automatic abortRun(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first failure.");
  endtask

  task automatic checkResult(input fp16_t expected);
    if (result !== expected) begin
      abortRun($sformatf("ERROR result expected 0x%04h actual 0x%04h", expected, result));
    end
  endtask

  task automatic checkValid(input logic expected);
    if (outValid !== expected) begin
      abortRun($sformatf("ERROR outValid expected 0x%1h actual 0x%1h", expected, outValid));
    end
  endtask

  // Lines that start with # are comments. Every other line holds four hex columns.
  task automatic loadTests();
    int          fd;
    int          fields;
    string       line;
    logic [3:0]  opBits;
    logic [15:0] aBits;
    logic [15:0] bBits;
    logic [15:0] eBits;
    fd = $fopen("tb/fpuAddSub_tests.txt", "r");
    if (fd == 0) begin
      abortRun("Could not open the test data file tb/fpuAddSub_tests.txt.");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        fields = $sscanf(line, "%h %h %h %h", opBits, aBits, bBits, eBits);
        if (fields == 4 && opBits <= 4'd1) begin
          testOp.push_back(fpuOp_e'(opBits[0]));     // Zero adds, one subtracts.
          testA.push_back(fp16_t'(aBits));
          testB.push_back(fp16_t'(bBits));
          testExp.push_back(fp16_t'(eBits));
        end else if (fields > 0) begin
          abortRun($sformatf("Malformed line in the test data file: %s", line));
        end
      end
    end
    $fclose(fd);
    if (testA.size() == 0) begin
      abortRun("The test data file holds no operations.");
    end
  endtask

  task automatic sendOp(input int idx);
    @(posedge clk);
    inValid <= 1'b1;
    op      <= testOp[idx];
    opA     <= testA[idx];
    opB     <= testB[idx];
    expQ.push_back(testExp[idx]);                    // Drained in order by the output monitor.
  endtask

  task automatic idleCycles(input int count);
    repeat (count) begin
      @(posedge clk);
      inValid <= 1'b0;
      opA     <= fp16_t'(~opA);                      // Junk operands must not reach result.
      opB     <= fp16_t'(~opB);
    end
  endtask

  task automatic waitForResults();
    while (expQ.size() != 0) begin
      @(posedge clk);                                // The cycle counter bounds this loop.
    end
  endtask

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > cycleLimit) begin
      abortRun($sformatf("Timeout after %0d cycles with %0d results never returned.",
                         cycleCount, expQ.size()));
    end
  end

  // Outputs change on the rising edge, so they are sampled on the falling one.
  always @(negedge clk) begin : outputMonitor
    logic expectValid;
    if (cycleCount > 0) begin
      if (DUT.uAsserts.failCount != 0) begin
        abortRun("A bound assertion on the DUT failed.");
      end
      if (!rstN) begin
        expQ.delete();                               // Operations in flight are lost.
        issueQ.delete();
        lastResult = '0;
        checkValid(1'b0);
        checkResult('0);
      end else begin
        if (inValid) begin
          issueQ.push_back(cycleCount);              // Sampled by the DUT at the next edge.
        end
        if (outValid && expQ.size() == 0) begin
          abortRun("outValid went high with no operation pending.");
        end
        expectValid = (issueQ.size() > 0) && (issueQ[0] + fpuLatency == cycleCount);
        checkValid(expectValid);
        if (outValid) begin
          lastResult = expQ.pop_front();
          void'(issueQ.pop_front());
        end
        checkResult(lastResult);                     // Between strobes the old value holds.
      end
    end
  end

  initial begin
    rstN       = 1'b0;
    inValid    = 1'b0;
    op         = FPU_ADD;
    opA        = '0;
    opB        = '0;
    lastResult = '0;
    loadTests();
    // Every cycle of the run plus room for late results.
    cycleLimit = 2 * resetCycles + testA.size() + (testA.size() / groupSize + 1) * gapCycles
               + replayCount + 2 + 3 * fpuLatency + gapCycles + 20;

    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;

    // Groups of back to back strobes with idle gaps in between.
    for (int i = 0; i < testA.size(); i++) begin
      sendOp(i);
      if ((i + 1) % groupSize == 0 || i == testA.size() - 1) begin
        idleCycles(gapCycles);
      end
    end
    waitForResults();

    // Reset lands while the replayed operations are still in the pipeline.
    for (int i = 0; i < replayCount; i++) begin
      sendOp(i);
    end
    @(posedge clk);
    inValid <= 1'b0;
    rstN    <= 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    idleCycles(fpuLatency + 3);                      // No stale strobe may come out here.

    // The pipeline works normally again after the reset.
    sendOp(1);
    sendOp(2);
    idleCycles(1);
    waitForResults();
    idleCycles(2);

    if (expQ.size() == 0 && DUT.uAsserts.failCount == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      abortRun("The run ended with pending results or a failed assertion.");
    end
  end

endmodule

// ==== tb/fpuAddSub_asserts.sv ====
`timescale 1ns/10ps

module fpuAddSubAsserts (
  input logic              clk,
  input logic              rstN,
  input logic              inValid,
  input logic              outValid,
  input fpTypesPkg::fp16_t result
);
  import fpuOpsPkg::*;

  int unsigned runCycles;          // Edges since reset release, saturating at fpuLatency.
  int unsigned failCount = 0;      // Read by the testbench to end the run on a failure.

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      runCycles <= 0;                                // Pipeline history is gone after reset.
    end else if (runCycles < fpuLatency) begin
      runCycles <= runCycles + 1;                    // Stops once every stage holds real data.
    end
  end

  // A strobe sampled at edge N comes out at edge N plus fpuLatency.
  property strobeDelay;
    @(posedge clk) disable iff (!rstN)
      (runCycles == fpuLatency) |-> (outValid == $past(inValid, fpuLatency));
  endproperty

  // Reset clears the output strobe and the result register.
  property resetClears;
    @(posedge clk) (!rstN && $past(!rstN)) |-> (!outValid && result == '0);
  endproperty

  // The result register only moves on the edge that raises outValid.
  property resultHolds;
    @(posedge clk) disable iff (!rstN)
      ($past(rstN) && !outValid) |-> $stable(result);
  endproperty

  assert property (strobeDelay) else begin
    $error("outValid does not follow inValid by the pipeline latency.");
    failCount = failCount + 1;
  end

  assert property (resetClears) else begin
    $error("outValid or result is not cleared while reset is held.");
    failCount = failCount + 1;
  end

  assert property (resultHolds) else begin
    $error("result changed while outValid stayed low.");
    failCount = failCount + 1;
  end

endmodule

// ==== rtl/fpuAddSub.sv ====
`timescale 1ns/10ps

module fpuAddSub (
  input  logic              clk,
  input  logic              rstN,
  input  logic              inValid,
  input  fpuOpsPkg::fpuOp_e op,
  input  fpTypesPkg::fp16_t opA,
  input  fpTypesPkg::fp16_t opB,
  output logic              outValid,
  output fpTypesPkg::fp16_t result
);
  import fpTypesPkg::*;
  import fpuOpsPkg::*;

  logic [fpuLatency - 1:0] validChain;  // Bit n is high while stage n + 1 holds live data.

  alignedPair_t alignedNext;  // Aligner output computed from the input ports.
  alignedPair_t alignedReg;   // First register captures the inputs already aligned.
  unnorm16_t    sumNext;      // Adder output from the aligned register.
  unnorm16_t    sumReg;       // Second register.
  fp16_t        normNext;     // Normalizer output from the sum register.

  // The aligner works on the ports directly, so the first register is the input register.
  fpuAddSubAligner uAligner (
    .op      (op),
    .opA     (opA),
    .opB     (opB),
    .aligned (alignedNext)
  );

  fpuFracAdder uAdder (
    .aligned (alignedReg),
    .sum     (sumNext)
  );

  fpuNormalizer16 uNormalizer (
    .unnormalizedIn (sumReg),
    .normalizedOut  (normNext)
  );

  // Valid strobes move one stage per clock with no stall.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validChain <= '0;                                     // No operation survives reset.
    end else begin
      validChain <= {validChain[fpuLatency - 2:0], inValid};  // Shift in the new strobe.
    end
  end

  // Stage one loads only when an operation arrives.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      alignedReg <= '0;
    end else if (inValid) begin
      alignedReg <= alignedNext;                            // Sorted and aligned pair.
    end
  end

  // Stage two follows the first valid bit.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      sumReg <= '0;
    end else if (validChain[0]) begin
      sumReg <= sumNext;                                    // Raw sum with its integer part.
    end
  end

  // Stage three holds the result between strobes.
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      result <= '0;                                         // Reads as plus zero after reset.
    end else if (validChain[1]) begin
      result <= normNext;                                   // Final normalized value.
    end
  end

  // The result register loads on the same edge that raises the last valid bit.
  assign outValid = validChain[fpuLatency - 1];

endmodule

// ==== rtl/fpuNormalizer16.sv ====
`timescale 1ns/10ps

module fpuNormalizer16 (
  input  fpTypesPkg::unnorm16_t unnormalizedIn,
  output fpTypesPkg::fp16_t     normalizedOut
);
  import fpTypesPkg::*;

  logic [fpExpW - 1:0]  lzc;       // Left shift that brings the top set fraction bit to 1.x.
  logic                 fracZero;  // No set bit below the binary point.
  logic                 canShift;  // The exponent stays normal after the left shift.
  logic [fpFracW + 1:0] wideVal;   // Integer part and fraction side by side.
  logic [fpExpW - 1:0]  expUp;     // Exponent after a carry.
  logic [fpExpW - 1:0]  expDown;   // Exponent after a left shift.
  logic [fpFracW - 1:0] fracUp;    // Fraction after the right shift.
  logic [fpFracW - 1:0] fracDown;  // Fraction after the left shift.

  // Priority leading zero counter that counts one extra for the hidden bit.
  // Scanning upward lets the highest set bit win.
  // A set bit 9 gives a shift of one and a set bit 0 gives ten.
  always_comb begin
    lzc = '0;                                       // Stays zero when the fraction is empty.
    for (int i = 0; i < fpFracW; i++) begin
      if (unnormalizedIn.frac[i]) begin
        lzc = fpExpW'(fpFracW - i);                 // Distance up to the hidden bit position.
      end
    end
  end

  assign fracZero = (unnormalizedIn.frac == '0);   // Marks an exact cancellation.

  // The shifted result must keep an exponent of at least one to stay normal.
  assign canShift = !fracZero && (lzc < unnormalizedIn.exp);

  assign wideVal  = {unnormalizedIn.leadingInt, unnormalizedIn.frac};
  assign expUp    = unnormalizedIn.exp + 1'b1;      // The test data keeps this below 31.
  assign fracUp   = wideVal[fpFracW:1];             // Bit zero drops off, which truncates.
  assign expDown  = unnormalizedIn.exp - lzc;       // Only used when canShift is set.
  assign fracDown = unnormalizedIn.frac << lzc;     // The leading one leaves as the hidden bit.

  always_comb begin
    normalizedOut.sign = unnormalizedIn.sign;       // Kept on every path except the flush.
    normalizedOut.exp  = unnormalizedIn.exp;
    normalizedOut.frac = unnormalizedIn.frac;
    if (unnormalizedIn.leadingInt > 2'd1) begin
      normalizedOut.exp  = expUp;                   // Carry out moves the point one place left.
      normalizedOut.frac = fracUp;
    end else if (unnormalizedIn.leadingInt == 2'd0) begin
      if (canShift) begin
        normalizedOut.exp  = expDown;               // Undo the cancellation of leading bits.
        normalizedOut.frac = fracDown;
      end else begin
        normalizedOut = '0;                         // Too small to normalize gives plus zero.
      end
    end
    // A leadingInt of one is already in 1.x form and passes through unchanged.
  end

endmodule

// ==== rtl/fpuFracAdder.sv ====
`timescale 1ns/10ps

module fpuFracAdder (
  input  fpTypesPkg::alignedPair_t aligned,
  output fpTypesPkg::unnorm16_t    sum
);
  import fpTypesPkg::*;

  logic [fpFracW + 1:0] largeExt;  // Larger significand with a zero carry bit on top.
  logic [fpFracW + 1:0] smallExt;  // Smaller significand with a zero carry bit on top.
  logic [fpFracW + 1:0] addRes;    // Sum when the signs agree.
  logic [fpFracW + 1:0] subRes;    // Difference when the signs differ.
  logic [fpFracW + 1:0] rawSum;    // Selected result with a two bit integer part.

  // Widen both significands by one bit so an addition can carry out.
  assign largeExt = {1'b0, aligned.largeSig};
  assign smallExt = {1'b0, aligned.smallSig};

  // Two hidden ones plus full fractions reach at most three in the integer part.
  assign addRes = largeExt + smallExt;

  // The sort keeps the small significand at or below the large one.
  // So the difference never wraps.
  // An exact cancellation gives zero here and is flushed later.
  assign subRes = largeExt - smallExt;

  assign rawSum = aligned.effSub ? subRes : addRes;  // Effective operation selects the path.

  always_comb begin
    sum.sign       = aligned.sign;                   // Sign of the larger magnitude.
    sum.exp        = aligned.exp;                    // Normalization adjusts this later.
    sum.leadingInt = rawSum[fpFracW + 1:fpFracW];    // Carry bit and hidden bit position.
    sum.frac       = rawSum[fpFracW - 1:0];          // Fraction below the binary point.
  end

  // leadingInt reads as follows.
  // Zero means a subtraction lost the leading one and a left shift is due.
  // One means the value is already normalized.
  // Two or three means an addition carried and a right shift by one is due.

endmodule

// ==== rtl/fpuAddSubAligner.sv ====
`timescale 1ns/10ps

module fpuAddSubAligner (
  input  fpuOpsPkg::fpuOp_e        op,
  input  fpTypesPkg::fp16_t        opA,
  input  fpTypesPkg::fp16_t        opB,
  output fpTypesPkg::alignedPair_t aligned
);
  import fpTypesPkg::*;
  import fpuOpsPkg::*;

  fp16_t               effB;         // Operand B after the subtract sign flip.
  fp16_t               largeNum;     // Operand with the larger magnitude.
  fp16_t               smallNum;     // Operand with the smaller or equal magnitude.
  logic                aIsLarger;    // Magnitude compare result.
  logic                largeHidden;  // Hidden bit of the larger operand.
  logic                smallHidden;  // Hidden bit of the smaller operand.
  logic [fpExpW - 1:0] expDiff;      // Right shift needed by the smaller significand.
  logic [fpFracW:0]    smallSig;     // Smaller significand after alignment.

  // Subtraction becomes addition of B with its sign inverted.
  always_comb begin
    effB      = opB;                              // Exponent and fraction pass unchanged.
    effB.sign = opB.sign ^ (op == FPU_SUB);       // Only the sign depends on the opcode.
  end

  // Exponent and fraction together order the magnitudes like one unsigned number.
  assign aIsLarger = {opA.exp, opA.frac} > {effB.exp, effB.frac};  // Ties pick B as large.

  always_comb begin
    if (aIsLarger) begin
      largeNum = opA;    // A already leads.
      smallNum = effB;   // B is aligned to A.
    end else begin
      largeNum = effB;   // B leads, or both magnitudes match.
      smallNum = opA;    // A is aligned to B.
    end
  end

  assign largeHidden = (largeNum.exp != '0);  // Denormals carry a leading zero.
  assign smallHidden = (smallNum.exp != '0);  // Same rule for the smaller operand.

  // The sort guarantees a non-negative difference.
  assign expDiff = largeNum.exp - smallNum.exp;

  // Bits shifted past the bottom are lost, which truncates the result.
  // A shift of eleven or more leaves zero, and the large operand then passes through.
  assign smallSig = {smallHidden, smallNum.frac} >> expDiff;

  always_comb begin
    aligned.sign     = largeNum.sign;                      // The larger operand sets the sign.
    aligned.exp      = largeNum.exp;                       // Both values now share this scale.
    aligned.largeSig = {largeHidden, largeNum.frac};       // Never shifted.
    aligned.smallSig = smallSig;                           // Shifted down to the common scale.
    aligned.effSub   = largeNum.sign ^ smallNum.sign;      // Opposite signs mean a subtraction.
  end

endmodule

// ==== rtl/fpuOpsPkg.sv ====
package fpuOpsPkg;

  // Operation select carried next to every operand pair.
  typedef enum logic {
    FPU_ADD = 1'b0,  // Result is A plus B.
    FPU_SUB = 1'b1   // Result is A minus B, done as A plus a negated B.
  } fpuOp_e;

  // Clock edges from a sampled input strobe to the matching output strobe.
  localparam int unsigned fpuLatency = 3;

  // The first edge captures the aligned pair straight from the inputs.
  // The second edge captures the raw sum.
  // The third edge captures the normalized result.
  // One operation can enter on every cycle.
  // So at most fpuLatency operations are in flight at once.
  // There is no ready signal.
  // The consumer takes the result in the cycle its strobe is high.
  // An older result stays on the output until the next strobe replaces it.
  // A new strobe can follow the previous one on the very next cycle.
  // Results then come out on consecutive cycles in the same order.
  // Idle cycles between strobes keep the result port unchanged.

endpackage

// ==== rtl/fpTypesPkg.sv ====
package fpTypesPkg;

  localparam int unsigned fpExpW    = 5;   // Biased exponent field width.
  localparam int unsigned fpFracW   = 10;  // Stored fraction width without the hidden bit.
  localparam int unsigned fpExpBias = 15;  // A stored exponent of 15 means a scale of 2^0.

  // IEEE half precision word in its natural bit order.
  typedef struct packed {
    logic                 sign;  // Set for negative values.
    logic [fpExpW - 1:0]  exp;   // Zero marks a denormal with no hidden bit.
    logic [fpFracW - 1:0] frac;  // Bits below the binary point.
  } fp16_t;

  // Operand pair after sorting and binary point alignment.
  typedef struct packed {
    logic                 sign;      // Sign of the larger magnitude operand.
    logic [fpExpW - 1:0]  exp;       // Common exponent taken from the larger operand.
    logic [fpFracW:0]     largeSig;  // Larger significand with its hidden bit on top.
    logic [fpFracW:0]     smallSig;  // Smaller significand already shifted right.
    logic                 effSub;    // Signs differ, so the significands are subtracted.
  } alignedPair_t;

  // Raw sum before normalization.
  typedef struct packed {
    logic                 sign;        // Result sign before any flush to zero.
    logic [fpExpW - 1:0]  exp;         // Exponent that still needs adjusting.
    logic [1:0]           leadingInt;  // Integer part, which can reach two or three on a carry.
    logic [fpFracW - 1:0] frac;        // Fraction bits of the raw sum.
  } unnorm16_t;

  // A normal value reads (-1)^sign * 1.frac * 2^(exp - fpExpBias).
  // A denormal reads (-1)^sign * 0.frac * 2^(1 - fpExpBias).
  // The datapath treats the raw exponent field as the scale for both.
  // So a denormal meets a normal operand at a shift one larger than IEEE would use.
  // Truncation is the only rounding the datapath performs.
  // Special encodings never reach the datapath.
  // NaN and infinity are among them.
  // Exponent overflow is kept out of the operand data too.

endpackage
